/* hw/mlpPkg.sv */
package mlpPkg;

	// vector and layer dimensions.
	localparam int DataWidth = 16;
	localparam int NumFeatures = 8;
	localparam int NumHidden = 6;
	localparam int NumClasses = 4;
	localparam int ClassWidth = 2;

	// layer selectors, each node uses one to find its rows in the tables below.
	localparam int HiddenLayer = 0;
	localparam int OutputLayer = 1;

	// one activation, weight or bias in two's complement.
	typedef logic [DataWidth-1:0] data_t;

	typedef logic [ClassWidth-1:0] classIdx_t;

	// network input, element 0 in the low bits.
	typedef struct packed {
		data_t [NumFeatures-1:0] elem;
	} featureVec_t;

	// hidden layer activations after relu.
	typedef struct packed {
		data_t [NumHidden-1:0] elem;
	} hiddenVec_t;

	// output layer scores, never negative after relu.
	typedef struct packed {
		data_t [NumClasses-1:0] elem;
	} scoreVec_t;

	// hidden layer weights, one row per node and one column per feature.
	localparam data_t hiddenWeights [NumHidden][NumFeatures] = '{
		'{
			12, -7, 3, 25,
			-18, 9, -4, 11
		},
		'{
			-5, 14, 21, -9,
			6, -13, 17, 2
		},
		'{
			8, 8, -16, 4,
			19, -2, -11, 23
		},
		'{
			-22, 5, 10, 15,
			-3, 27, 6, -8
		},
		'{
			3, -19, 7, -6,
			12, 4, 26, -14
		},
		'{
			16, 11, -8, -12,
			-7, 13, 9, 5
		}
	};

	// hidden layer biases, one per node.
	localparam data_t hiddenBias [NumHidden] = '{
		10,
		-25,
		4,
		-12,
		30,
		-6
	};

	// output layer weights, one row per class and one column per hidden node.
	localparam data_t outputWeights [NumClasses][NumHidden] = '{
		'{
			9, -4, 13, 6,
			-11, 7
		},
		'{
			-6, 15, 3, -10,
			8, 12
		},
		'{
			14, 2, -9, 11,
			5, -13
		},
		'{
			-3, -8, 10, 16,
			4, 1
		}
	};

	// output layer biases, one per class.
	localparam data_t outputBias [NumClasses] = '{
		-20,
		-15,
		-18,
		-9
	};

endpackage

/* hw/neuronNode.sv */
`timescale 1ns/1ps

module neuronNode
	import mlpPkg::*;
#(
	parameter type inVec_t = featureVec_t,
	parameter int Layer = HiddenLayer,
	parameter int NodeIdx = 0
)
(
	input logic clk,
	input logic reset,
	input inVec_t activations,
	output data_t result
);

	// input count comes from the payload width.
	localparam int NumIn = $bits(inVec_t) / DataWidth;

	data_t [NumIn-1:0] weights;
	data_t bias;
	data_t [NumIn-1:0] actReg;
	data_t [NumIn-1:0] products;
	data_t sumNext;
	data_t sumReg;

	// pick this node's row from the table of its layer.
	if (Layer == HiddenLayer)
	begin : gHiddenRow
		for (genvar i = 0; i < NumIn; i++)
		begin : gWeight
			assign weights[i] = hiddenWeights[NodeIdx][i];
		end
		assign bias = hiddenBias[NodeIdx];
	end
	else
	begin : gOutputRow
		for (genvar i = 0; i < NumIn; i++)
		begin : gWeight
			assign weights[i] = outputWeights[NodeIdx][i];
		end
		assign bias = outputBias[NodeIdx];
	end

	// only the low half of each product is kept.
	always_comb
	begin
		for (int i = 0; i < NumIn; i++)
		begin
			products[i] = actReg[i] * weights[i];
		end
	end

	// accumulate with 16-bit wraparound, starting from the bias.
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < NumIn; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
		end
		else
		begin
			actReg <= activations;
			sumReg <= sumNext;
		end
	end

	// relu stage.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (sumReg[DataWidth-1])
		begin
			result <= '0;
		end
		else
		begin
			result <= sumReg;
		end
	end

endmodule

/* hw/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer
	import mlpPkg::*;
#(
	parameter type inVec_t = featureVec_t,
	parameter type outVec_t = hiddenVec_t,
	parameter int Layer = HiddenLayer
)
(
	input logic clk,
	input logic reset,
	input inVec_t activations,
	output outVec_t results
);

	// one node per element of the output vector.
	localparam int NumOut = $bits(outVec_t) / DataWidth;

	data_t [NumOut-1:0] nodeResults;

	for (genvar n = 0; n < NumOut; n++)
	begin : gNode
		neuronNode #(
			.inVec_t(inVec_t),
			.Layer(Layer),
			.NodeIdx(n)
		) i_neuronNode (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.result(nodeResults[n])
		);
	end

	// node n lands in element n.
	assign results = nodeResults;

endmodule

/* hw/argmaxUnit.sv */
`timescale 1ns/1ps

module argmaxUnit
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input scoreVec_t scores,
	output classIdx_t classIdx,
	output data_t maxScore
);

	data_t bestScore;
	classIdx_t bestIdx;

	// scores are non-negative here, so an unsigned compare is enough.
	always_comb
	begin
		bestScore = scores.elem[0];
		bestIdx = '0;
		for (int c = 1; c < NumClasses; c++)
		begin
			// strict greater keeps the lower index on a tie.
			if (scores.elem[c] > bestScore)
			begin
				bestScore = scores.elem[c];
				bestIdx = classIdx_t'(c);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIdx <= '0;
			maxScore <= '0;
		end
		else
		begin
			classIdx <= bestIdx;
			maxScore <= bestScore;
		end
	end

endmodule

/* hw/mlpClassifier.sv */
`timescale 1ns/1ps

module mlpClassifier
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input featureVec_t features,
	output scoreVec_t scores,
	output classIdx_t classIdx,
	output data_t maxScore
);

	hiddenVec_t hidden;

	// features to hidden activations, 3 cycles.
	denseLayer #(
		.inVec_t(featureVec_t),
		.outVec_t(hiddenVec_t),
		.Layer(HiddenLayer)
	) i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.activations(features),
		.results(hidden)
	);

	// hidden activations to class scores, another 3 cycles.
	denseLayer #(
		.inVec_t(hiddenVec_t),
		.outVec_t(scoreVec_t),
		.Layer(OutputLayer)
	) i_outputLayer (
		.clk(clk),
		.reset(reset),
		.activations(hidden),
		.results(scores)
	);

	// winning class one cycle after the scores.
	argmaxUnit i_argmaxUnit (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIdx(classIdx),
		.maxScore(maxScore)
	);

endmodule

/* dv/mlpRefModel.svh */
`ifndef MLP_REF_MODEL_SVH
`define MLP_REF_MODEL_SVH

// weight of one connection, looked up by layer, node row and input column.
function automatic data_t modelWeight(input int layer, input int node, input int col);
	if (layer == HiddenLayer)
	begin
		return hiddenWeights[node][col];
	end
	else
	begin
		return outputWeights[node][col];
	end
endfunction

function automatic data_t modelBias(input int layer, input int node);
	if (layer == HiddenLayer)
	begin
		return hiddenBias[node];
	end
	else
	begin
		return outputBias[node];
	end
endfunction

// one node: full signed product, low 16 bits kept, wrapped sum, relu on the sign bit.
function automatic data_t modelNode(input int layer, input int node,
		input data_t acts [NumFeatures], input int numIn);
	logic signed [31:0] fullProd;
	data_t acc;
	acc = modelBias(layer, node);
	for (int i = 0; i < numIn; i++)
	begin
		fullProd = $signed(acts[i]) * $signed(modelWeight(layer, node, i));
		acc = acc + fullProd[DataWidth-1:0];
	end
	if (acc[DataWidth-1])
	begin
		return '0;
	end
	return acc;
endfunction

// both layers back to back.
function automatic scoreVec_t modelNetwork(input featureVec_t f);
	data_t acts [NumFeatures];
	data_t hid [NumFeatures];
	scoreVec_t s;
	for (int i = 0; i < NumFeatures; i++)
	begin
		acts[i] = f.elem[i];
		hid[i] = '0;
	end
	for (int n = 0; n < NumHidden; n++)
	begin
		hid[n] = modelNode(HiddenLayer, n, acts, NumFeatures);
	end
	for (int c = 0; c < NumClasses; c++)
	begin
		s.elem[c] = modelNode(OutputLayer, c, hid, NumHidden);
	end
	return s;
endfunction

// largest score as unsigned, first index wins a tie.
function automatic void modelArgmax(input scoreVec_t s, output classIdx_t idx,
		output data_t best);
	int bestIdx;
	bestIdx = 0;
	for (int c = 1; c < NumClasses; c++)
	begin
		if (s.elem[c] > s.elem[bestIdx])
		begin
			bestIdx = c;
		end
	end
	idx = classIdx_t'(bestIdx);
	best = s.elem[bestIdx];
endfunction

`endif

/* dv/mlpClassifierTb.sv */
`timescale 1ns/1ps

module mlpClassifierTb
	import mlpPkg::*;
();

	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 10;
	localparam int NumDirected = 16;
	localparam int NumRandom = 72;
	localparam int TableLen = NumDirected + NumRandom;
	localparam int ScoreLatency = 6;
	localparam int ClassLatency = 7;
	localparam int Seed = 53;
	localparam int TimeoutNs = (ResetCycles + TableLen + ClassLatency + 20) * ClkPeriod;

	`include "mlpRefModel.svh"

	typedef struct packed {
		featureVec_t features;
		scoreVec_t scores;
		classIdx_t classIdx;
		data_t maxScore;
	} stimRow_t;

	logic clk;
	logic reset;
	featureVec_t features;
	scoreVec_t scores;
	classIdx_t classIdx;
	data_t maxScore;

	stimRow_t stimTable [TableLen];
	logic [31:0] rngState;

	mlpClassifier i_mlpClassifier (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIdx(classIdx),
		.maxScore(maxScore)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic featureVec_t makeVec(input int v0, input int v1, input int v2,
			input int v3, input int v4, input int v5, input int v6, input int v7);
		int v [NumFeatures];
		featureVec_t f;
		v = '{v0, v1, v2, v3, v4, v5, v6, v7};
		for (int i = 0; i < NumFeatures; i++)
		begin
			f.elem[i] = data_t'(v[i]);
		end
		return f;
	endfunction

	function automatic featureVec_t directedVec(input int r);
		case (r)
			0: return makeVec(0, 0, 0, 0, 0, 0, 0, 0);
			1: return makeVec(1, 0, 0, 0, 0, 0, 0, 0);
			2: return makeVec(0, 0, 0, 50, 0, 0, 0, 0);
			3: return makeVec(0, 0, 0, 0, 0, 0, 0, -30);
			4: return makeVec(0, 0, 0, 0, 0, 0, 20, 0);
			5: return makeVec(1, 2, 3, 4, 5, 6, 7, 8);
			6: return makeVec(10, 3, 7, 1, 9, 2, 4, 6);
			7: return makeVec(5, 5, 5, 5, 5, 5, 5, 5);
			// every hidden sum negative, so all four scores tie at zero.
			8: return makeVec(0, 0, 0, -2, 0, 0, -3, -2);
			9: return makeVec(0, 0, 0, -4, 0, 0, -6, -4);
			10: return makeVec(0, 0, 0, -8, 0, 0, -12, -8);
			// large magnitudes overflow products and sums.
			11: return makeVec(32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767);
			12: return makeVec(-32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767);
			13: return makeVec(20000, -15000, 30000, -25000, 12345, -31000, 27000, -9999);
			14: return makeVec(4096, 4096, 4096, 4096, 4096, 4096, 4096, 4096);
			15: return makeVec(1000, -2000, 3000, -4000, 5000, -6000, 7000, -8000);
			default: return '0;
		endcase
	endfunction

	task automatic buildTable();
		featureVec_t f;
		classIdx_t idx;
		data_t best;
		rngState = Seed;
		for (int r = 0; r < TableLen; r++)
		begin
			if (r < NumDirected)
			begin
				f = directedVec(r);
			end
			else
			begin
				for (int i = 0; i < NumFeatures; i++)
				begin
					rngState = xorshift32(rngState);
					// odd rows use small values so that more scores stay positive.
					if (r % 2 == 0)
					begin
						f.elem[i] = rngState[15:0];
					end
					else
					begin
						f.elem[i] = {{9{rngState[6]}}, rngState[6:0]};
					end
				end
			end
			stimTable[r].features = f;
			stimTable[r].scores = modelNetwork(f);
			modelArgmax(stimTable[r].scores, idx, best);
			stimTable[r].classIdx = idx;
			stimTable[r].maxScore = best;
		end
	endtask

	task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	initial
	begin
		reset = 1'b1;
		features = '0;
		buildTable();

		// outputs stay cleared while reset is held, and on the last reset edge.
		for (int r = 0; r < ResetCycles; r++)
		begin
			@(posedge clk);
			if (r == ResetCycles - 1)
			begin
				reset <= 1'b0;
			end
			@(negedge clk);
			checkValue(scores, 64'd0, "scores in reset");
			checkValue(classIdx, 64'd0, "classIdx in reset");
			checkValue(maxScore, 64'd0, "maxScore in reset");
		end

		// one row per clock and results compared at the fixed pipeline latency.
		for (int cyc = 0; cyc < TableLen + ClassLatency; cyc++)
		begin
			@(posedge clk);
			if (cyc < TableLen)
			begin
				features <= stimTable[cyc].features;
			end
			else
			begin
				features <= '0;
			end
			@(negedge clk);
			if (cyc >= ScoreLatency && cyc - ScoreLatency < TableLen)
			begin
				checkValue(scores, stimTable[cyc - ScoreLatency].scores,
					$sformatf("scores of row %0d", cyc - ScoreLatency));
			end
			if (cyc >= ClassLatency)
			begin
				checkValue(classIdx, stimTable[cyc - ClassLatency].classIdx,
					$sformatf("classIdx of row %0d", cyc - ClassLatency));
				checkValue(maxScore, stimTable[cyc - ClassLatency].maxScore,
					$sformatf("maxScore of row %0d", cyc - ClassLatency));
			end
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

	// ends a run that stops making progress.
	initial
	begin
		#(TimeoutNs);
		$display("watchdog timeout, the run did not finish within %0d ns", TimeoutNs);
		$display("CHECKS FAILED");
		$fatal(1, "simulation timed out");
	end

endmodule

/* mlpClassifier.f */
+incdir+dv
hw/mlpPkg.sv
hw/neuronNode.sv
hw/denseLayer.sv
hw/argmaxUnit.sv
hw/mlpClassifier.sv
dv/mlpClassifierTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = mlpClassifierTb
FILELIST = mlpClassifier.f

BUILD_DIR = obj_dir
LOG       = sim.log
BIN       = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
